//--- hw/bridge_pkg.sv
package bridge_pkg;

    // Serial bit period in clk cycles, kept short for simulation
    localparam logic [15:0] CLKS_PER_BIT = 16'd16;

    // Frame markers
    localparam logic [7:0] REQ_SOF = 8'hA5;     // Host to bridge
    localparam logic [7:0] RSP_SOF = 8'h5A;     // Bridge to host

    // Command bytes
    localparam logic [7:0] CMD_WRITE = 8'h00;
    localparam logic [7:0] CMD_READ  = 8'h80;

    // Response status codes
    localparam logic [7:0] ST_OK        = 8'h00;
    localparam logic [7:0] ST_CHECKSUM  = 8'h01;
    localparam logic [7:0] ST_BAD_CMD   = 8'h02;
    localparam logic [7:0] ST_BUS_ERR   = 8'h03;    // BRESP or RRESP nonzero
    localparam logic [7:0] ST_UNALIGNED = 8'h04;

    // Datapath widths
    localparam int ADDR_W  = 32;
    localparam int DATA_W  = 32;
    localparam int COUNT_W = 16;

endpackage

//--- hw/uart_rx.sv
`timescale 1ns/1ps

module uart_rx (
    input  logic       clk,
    input  logic       rst,
    input  logic       rxd,
    output logic [7:0] rx_byte,
    output logic       rx_valid
);

    logic        rxd_meta;
    logic        rxd_sync;
    logic        rxd_prev;      // For falling edge of start bit
    logic        busy;
    logic [3:0]  bit_idx;       // 0 start, 1..8 data, 9 stop
    logic [15:0] cnt;
    logic        sample;

    // Mid-bit point, half a period in for the start bit
    assign sample = (bit_idx == 4'd0) ? (cnt == bridge_pkg::CLKS_PER_BIT / 2 - 16'd1)
                                      : (cnt == bridge_pkg::CLKS_PER_BIT - 16'd1);

    always_ff @(posedge clk) begin
        if (rst) begin
            rxd_meta <= 1'b1;   // Line idles high
            rxd_sync <= 1'b1;
            rxd_prev <= 1'b1;
            busy     <= 1'b0;
            bit_idx  <= 4'd0;
            cnt      <= 16'd0;
            rx_valid <= 1'b0;
        end else begin
            rxd_meta <= rxd;
            rxd_sync <= rxd_meta;
            rxd_prev <= rxd_sync;
            rx_valid <= 1'b0;
            if (!busy) begin
                if (rxd_prev && !rxd_sync) begin   // Start edge
                    busy    <= 1'b1;
                    bit_idx <= 4'd0;
                    cnt     <= 16'd0;
                end
            end else if (sample) begin
                cnt     <= 16'd0;
                bit_idx <= bit_idx + 4'd1;
                if (bit_idx == 4'd0) begin
                    // Glitch, line back high at mid start bit
                    if (rxd_sync) begin
                        busy <= 1'b0;
                    end
                end else if (bit_idx == 4'd9) begin
                    busy     <= 1'b0;
                    rx_valid <= rxd_sync;   // Framing error drops the byte
                end else begin
                    rx_byte <= {rxd_sync, rx_byte[7:1]};   // LSB first
                end
            end else begin
                cnt <= cnt + 16'd1;
            end
        end
    end

endmodule

//--- hw/uart_tx.sv
`timescale 1ns/1ps

module uart_tx (
    input  logic       clk,
    input  logic       rst,
    input  logic [7:0] tx_byte,
    input  logic       tx_valid,
    output logic       tx_ready,
    output logic       txd
);

    logic [8:0]  shift;         // Data bits then stop bit
    logic [3:0]  bits_left;     // Bit periods still to run
    logic [15:0] cnt;

    assign tx_ready = (bits_left == 4'd0);  // Idle only

    always_ff @(posedge clk) begin
        if (rst) begin
            txd       <= 1'b1;
            bits_left <= 4'd0;
            cnt       <= 16'd0;
        end else if (tx_valid && tx_ready) begin
            txd       <= 1'b0;                  // Start bit
            shift     <= {1'b1, tx_byte};
            bits_left <= 4'd10;
            cnt       <= 16'd0;
        end else if (bits_left != 4'd0) begin
            if (cnt == bridge_pkg::CLKS_PER_BIT - 16'd1) begin
                cnt       <= 16'd0;
                bits_left <= bits_left - 4'd1;
                txd       <= shift[0];
                shift     <= {1'b1, shift[8:1]};    // Backfill keeps line high
            end else begin
                cnt <= cnt + 16'd1;
            end
        end
    end

endmodule

//--- hw/frame_parser.sv
`timescale 1ns/1ps

module frame_parser (
    input  logic                          clk,
    input  logic                          rst,
    input  logic [7:0]                    rx_byte,
    input  logic                          rx_valid,
    output logic                          req_valid,
    input  logic                          req_ready,
    output logic                          req_read,
    output logic [bridge_pkg::ADDR_W-1:0] req_addr,
    output logic [bridge_pkg::DATA_W-1:0] req_wdata,
    output logic [7:0]                    req_status
);

    logic       in_frame;       // SOF seen
    logic [3:0] idx;            // Byte index after SOF, 0 is CMD
    logic [7:0] cmd;
    logic [7:0] xsum;           // Running XOR of CMD onwards
    logic       is_write;
    logic       last_byte;
    logic [7:0] status;

    // Only a write carries data, anything else is read length
    assign is_write  = (cmd == bridge_pkg::CMD_WRITE);
    assign last_byte = in_frame && (idx == (is_write ? 4'd9 : 4'd5));

    // Error priority: checksum, command, alignment
    always_comb begin
        if ((xsum ^ rx_byte) != 8'h00) begin
            status = bridge_pkg::ST_CHECKSUM;
        end else if (!is_write && cmd != bridge_pkg::CMD_READ) begin
            status = bridge_pkg::ST_BAD_CMD;
        end else if (req_addr[1:0] != 2'b00) begin
            status = bridge_pkg::ST_UNALIGNED;
        end else begin
            status = bridge_pkg::ST_OK;
        end
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            in_frame  <= 1'b0;
            idx       <= 4'd0;
            xsum      <= 8'h00;
            req_valid <= 1'b0;
        end else if (req_valid) begin
            // Holding a request, incoming bytes are lost
            if (req_ready) begin
                req_valid <= 1'b0;
            end
        end else if (rx_valid) begin
            if (!in_frame) begin
                if (rx_byte == bridge_pkg::REQ_SOF) begin  // Hunt
                    in_frame <= 1'b1;
                    idx      <= 4'd0;
                    xsum     <= 8'h00;
                end
            end else begin
                idx  <= idx + 4'd1;
                xsum <= xsum ^ rx_byte;
                if (last_byte) begin
                    in_frame   <= 1'b0;
                    req_valid  <= 1'b1;     // Cycle after checksum byte
                    req_status <= status;
                    req_read   <= !is_write;
                end else if (idx == 4'd0) begin
                    cmd <= rx_byte;
                end else if (idx <= 4'd4) begin
                    req_addr <= {rx_byte, req_addr[bridge_pkg::ADDR_W-1:8]};   // LSB first
                end else begin
                    req_wdata <= {rx_byte, req_wdata[bridge_pkg::DATA_W-1:8]};
                end
            end
        end
    end

endmodule

//--- hw/axi_lite_master.sv
`timescale 1ns/1ps

module axi_lite_master (
    input  logic                          clk,
    input  logic                          rst,
    input  logic                          req_valid,
    output logic                          req_ready,
    input  logic                          req_read,
    input  logic [bridge_pkg::ADDR_W-1:0] req_addr,
    input  logic [bridge_pkg::DATA_W-1:0] req_wdata,
    input  logic [7:0]                    req_status,
    output logic [bridge_pkg::ADDR_W-1:0] awaddr,
    output logic                          awvalid,
    input  logic                          awready,
    output logic [bridge_pkg::DATA_W-1:0] wdata,
    output logic                          wvalid,
    input  logic                          wready,
    input  logic [1:0]                    bresp,
    input  logic                          bvalid,
    output logic                          bready,
    output logic [bridge_pkg::ADDR_W-1:0] araddr,
    output logic                          arvalid,
    input  logic                          arready,
    input  logic [bridge_pkg::DATA_W-1:0] rdata,
    input  logic [1:0]                    rresp,
    input  logic                          rvalid,
    output logic                          rready,
    output logic                          rsp_valid,
    input  logic                          rsp_ready,
    output logic [7:0]                    rsp_cmd,
    output logic [7:0]                    rsp_status,
    output logic [bridge_pkg::DATA_W-1:0] rsp_rdata
);

    logic [bridge_pkg::ADDR_W-1:0] addr_q;     // Shared by AW and AR

    assign awaddr = addr_q;
    assign araddr = addr_q;

    // Channel flags double as the FSM state
    assign req_ready = !(awvalid || wvalid || bready || arvalid || rready || rsp_valid);

    always_ff @(posedge clk) begin
        if (rst) begin
            awvalid   <= 1'b0;
            wvalid    <= 1'b0;
            bready    <= 1'b0;
            arvalid   <= 1'b0;
            rready    <= 1'b0;
            rsp_valid <= 1'b0;
        end else begin
            if (req_valid && req_ready) begin
                addr_q  <= req_addr;
                wdata   <= req_wdata;
                rsp_cmd <= req_read ? bridge_pkg::CMD_READ : bridge_pkg::CMD_WRITE;
                if (req_status != bridge_pkg::ST_OK) begin
                    // Bypass bus, answer next cycle
                    rsp_valid  <= 1'b1;
                    rsp_status <= req_status;
                    if (req_status == bridge_pkg::ST_BAD_CMD) begin
                        rsp_cmd <= 8'hFF;
                    end
                end else if (req_read) begin
                    arvalid <= 1'b1;
                end else begin
                    awvalid <= 1'b1;
                    wvalid  <= 1'b1;
                end
            end
            // AW and W complete independently
            if (awvalid && awready) begin
                awvalid <= 1'b0;
            end
            if (wvalid && wready) begin
                wvalid <= 1'b0;
            end
            if ((awvalid || wvalid) && (!awvalid || awready) && (!wvalid || wready)) begin
                bready <= 1'b1;
            end
            if (bready && bvalid) begin
                bready     <= 1'b0;
                rsp_valid  <= 1'b1;
                rsp_status <= (bresp != 2'b00) ? bridge_pkg::ST_BUS_ERR : bridge_pkg::ST_OK;
            end
            if (arvalid && arready) begin
                arvalid <= 1'b0;
                rready  <= 1'b1;
            end
            if (rready && rvalid) begin
                rready     <= 1'b0;
                rsp_valid  <= 1'b1;
                rsp_rdata  <= rdata;
                rsp_status <= (rresp != 2'b00) ? bridge_pkg::ST_BUS_ERR : bridge_pkg::ST_OK;
            end
            if (rsp_valid && rsp_ready) begin
                rsp_valid <= 1'b0;
            end
        end
    end

endmodule

//--- hw/frame_builder.sv
`timescale 1ns/1ps

module frame_builder (
    input  logic                          clk,
    input  logic                          rst,
    input  logic                          rsp_valid,
    output logic                          rsp_ready,
    input  logic [7:0]                    rsp_cmd,
    input  logic [7:0]                    rsp_status,
    input  logic [bridge_pkg::DATA_W-1:0] rsp_rdata,
    output logic [7:0]                    tx_byte,
    output logic                          tx_valid,
    input  logic                          tx_ready
);

    logic [2:0]                    step;    // 0 SOF, 1 status, 2 cmd, 3..6 data, 7 checksum
    logic [7:0]                    cmd_q;
    logic [7:0]                    status_q;
    logic [bridge_pkg::DATA_W-1:0] data_q;
    logic [7:0]                    xsum;
    logic                          has_data;

    assign rsp_ready = !tx_valid;
    assign has_data  = (cmd_q == bridge_pkg::CMD_READ) && (status_q == bridge_pkg::ST_OK);

    always_comb begin
        case (step)
            3'd0:    tx_byte = bridge_pkg::RSP_SOF;
            3'd1:    tx_byte = status_q;
            3'd2:    tx_byte = cmd_q;
            3'd7:    tx_byte = xsum;
            default: tx_byte = data_q[7:0];    // Read data LSB first
        endcase
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            tx_valid <= 1'b0;
            step     <= 3'd0;
        end else if (rsp_valid && rsp_ready) begin
            tx_valid <= 1'b1;
            step     <= 3'd0;
            cmd_q    <= rsp_cmd;
            status_q <= rsp_status;
            data_q   <= rsp_rdata;
            xsum     <= 8'h00;
        end else if (tx_valid && tx_ready) begin
            if (step != 3'd0) begin
                xsum <= xsum ^ tx_byte;     // SOF not covered
            end
            if (step >= 3'd3) begin
                data_q <= data_q >> 8;
            end
            if (step == 3'd7) begin
                tx_valid <= 1'b0;           // Frame done
            end else if (step == 3'd2 && !has_data) begin
                step <= 3'd7;
            end else begin
                step <= step + 3'd1;
            end
        end
    end

endmodule

//--- hw/uart_axi_bridge.sv
`timescale 1ns/1ps

module uart_axi_bridge (
    input  logic                           clk,
    input  logic                           rst,
    input  logic                           rxd,
    output logic                           txd,
    output logic [bridge_pkg::ADDR_W-1:0]  awaddr,
    output logic                           awvalid,
    input  logic                           awready,
    output logic [bridge_pkg::DATA_W-1:0]  wdata,
    output logic                           wvalid,
    input  logic                           wready,
    input  logic [1:0]                     bresp,
    input  logic                           bvalid,
    output logic                           bready,
    output logic [bridge_pkg::ADDR_W-1:0]  araddr,
    output logic                           arvalid,
    input  logic                           arready,
    input  logic [bridge_pkg::DATA_W-1:0]  rdata,
    input  logic [1:0]                     rresp,
    input  logic                           rvalid,
    output logic                           rready,
    input  logic                           clear_counts,
    output logic [bridge_pkg::COUNT_W-1:0] write_count,
    output logic [bridge_pkg::COUNT_W-1:0] read_count,
    output logic                           busy
);

    logic [7:0]                    rx_byte;
    logic                          rx_valid;
    logic                          req_valid;
    logic                          req_ready;
    logic                          req_read;
    logic [bridge_pkg::ADDR_W-1:0] req_addr;
    logic [bridge_pkg::DATA_W-1:0] req_wdata;
    logic [7:0]                    req_status;
    logic                          rsp_valid;
    logic                          rsp_ready;
    logic [7:0]                    rsp_cmd;
    logic [7:0]                    rsp_status;
    logic [bridge_pkg::DATA_W-1:0] rsp_rdata;
    logic [7:0]                    tx_byte;
    logic                          tx_valid;
    logic                          tx_ready;
    logic                          rsp_ok;

    uart_rx u_rx (
        .clk(clk), .rst(rst), .rxd(rxd), .rx_byte(rx_byte), .rx_valid(rx_valid)
    );

    frame_parser u_parser (
        .clk(clk), .rst(rst), .rx_byte(rx_byte), .rx_valid(rx_valid),
        .req_valid(req_valid), .req_ready(req_ready), .req_read(req_read),
        .req_addr(req_addr), .req_wdata(req_wdata), .req_status(req_status)
    );

    axi_lite_master u_master (
        .clk(clk), .rst(rst),
        .req_valid(req_valid), .req_ready(req_ready), .req_read(req_read),
        .req_addr(req_addr), .req_wdata(req_wdata), .req_status(req_status),
        .awaddr(awaddr), .awvalid(awvalid), .awready(awready),
        .wdata(wdata), .wvalid(wvalid), .wready(wready),
        .bresp(bresp), .bvalid(bvalid), .bready(bready),
        .araddr(araddr), .arvalid(arvalid), .arready(arready),
        .rdata(rdata), .rresp(rresp), .rvalid(rvalid), .rready(rready),
        .rsp_valid(rsp_valid), .rsp_ready(rsp_ready), .rsp_cmd(rsp_cmd),
        .rsp_status(rsp_status), .rsp_rdata(rsp_rdata)
    );

    frame_builder u_builder (
        .clk(clk), .rst(rst),
        .rsp_valid(rsp_valid), .rsp_ready(rsp_ready), .rsp_cmd(rsp_cmd),
        .rsp_status(rsp_status), .rsp_rdata(rsp_rdata),
        .tx_byte(tx_byte), .tx_valid(tx_valid), .tx_ready(tx_ready)
    );

    uart_tx u_tx (
        .clk(clk), .rst(rst), .tx_byte(tx_byte), .tx_valid(tx_valid),
        .tx_ready(tx_ready), .txd(txd)
    );

    // Successful transfer leaving the bus stage
    assign rsp_ok = rsp_valid && rsp_ready && (rsp_status == bridge_pkg::ST_OK);

    // Master not ready covers bus phase and held response
    assign busy = req_valid || !req_ready || !rsp_ready || !tx_ready;

    always_ff @(posedge clk) begin
        if (rst || clear_counts) begin
            write_count <= '0;
            read_count  <= '0;
        end else if (rsp_ok) begin
            if (rsp_cmd == bridge_pkg::CMD_READ) begin
                read_count <= read_count + 1'b1;
            end else if (rsp_cmd == bridge_pkg::CMD_WRITE) begin
                write_count <= write_count + 1'b1;
            end
        end
    end

endmodule

//--- tests/tb_axi_mem.sv
`timescale 1ns/1ps

module tb_axi_mem (
    input  logic        clk,
    input  logic        rst,
    input  logic [31:0] awaddr,
    input  logic        awvalid,
    output logic        awready,
    input  logic [31:0] wdata,
    input  logic        wvalid,
    output logic        wready,
    output logic [1:0]  bresp,
    output logic        bvalid,
    input  logic        bready,
    input  logic [31:0] araddr,
    input  logic        arvalid,
    output logic        arready,
    output logic [31:0] rdata,
    output logic [1:0]  rresp,
    output logic        rvalid,
    input  logic        rready
);

    logic [31:0] mem [16];      // Words at 0x00 to 0x3C
    logic        aw_got;
    logic        w_got;
    logic        ar_got;
    logic [31:0] wr_addr;
    logic [31:0] wr_data;
    logic [31:0] rd_addr;

    always_ff @(posedge clk) begin
        if (rst) begin
            awready <= 1'b0;
            wready  <= 1'b0;
            arready <= 1'b0;
            bvalid  <= 1'b0;
            rvalid  <= 1'b0;
            bresp   <= 2'b00;
            rresp   <= 2'b00;
            aw_got  <= 1'b0;
            w_got   <= 1'b0;
            ar_got  <= 1'b0;
            for (int i = 0; i < 16; i++) begin
                mem[i] <= 32'h0101_0101 * (32'(i) * 32'd4 + 32'd7);  // Byte address based
            end
        end else begin
            // One-cycle ready pulses after a random wait
            awready <= awvalid && !awready && !aw_got && ($urandom_range(0, 3) == 0);
            wready  <= wvalid && !wready && !w_got && ($urandom_range(0, 3) == 0);
            arready <= arvalid && !arready && !ar_got && ($urandom_range(0, 3) == 0);
            if (awvalid && awready) begin
                aw_got  <= 1'b1;
                wr_addr <= awaddr;
            end
            if (wvalid && wready) begin
                w_got   <= 1'b1;
                wr_data <= wdata;
            end
            if (aw_got && w_got && !bvalid && ($urandom_range(0, 3) == 0)) begin
                bvalid <= 1'b1;
                aw_got <= 1'b0;
                w_got  <= 1'b0;
                if (wr_addr < 32'h40) begin
                    bresp              <= 2'b00;
                    mem[wr_addr[5:2]]  <= wr_data;
                end else begin
                    bresp <= 2'b10;     // SLVERR, unmapped
                end
            end
            if (bvalid && bready) begin
                bvalid <= 1'b0;
            end
            if (arvalid && arready) begin
                ar_got  <= 1'b1;
                rd_addr <= araddr;
            end
            if (ar_got && !rvalid && ($urandom_range(0, 3) == 0)) begin
                rvalid <= 1'b1;
                ar_got <= 1'b0;
                if (rd_addr < 32'h40) begin
                    rdata <= mem[rd_addr[5:2]];
                    rresp <= 2'b00;
                end else begin
                    rdata <= 32'h0;
                    rresp <= 2'b10;
                end
            end
            if (rvalid && rready) begin
                rvalid <= 1'b0;
            end
        end
    end

endmodule

//--- tests/tb_uart_axi_bridge.sv
`timescale 1ns/1ps

module tb_uart_axi_bridge;

    typedef logic [7:0] byte_q_t[$];
    typedef logic [31:0] mem_t[16];

    localparam int CYCLE_LIMIT = 250000;    // ~60 transactions of ~3000 cycles
    localparam int RANDOM_REQS = 40;

    logic                           clk;
    logic                           rst;
    logic                           rxd;
    logic                           txd;
    logic [bridge_pkg::ADDR_W-1:0]  awaddr;
    logic                           awvalid;
    logic                           awready;
    logic [bridge_pkg::DATA_W-1:0]  wdata;
    logic                           wvalid;
    logic                           wready;
    logic [1:0]                     bresp;
    logic                           bvalid;
    logic                           bready;
    logic [bridge_pkg::ADDR_W-1:0]  araddr;
    logic                           arvalid;
    logic                           arready;
    logic [bridge_pkg::DATA_W-1:0]  rdata;
    logic [1:0]                     rresp;
    logic                           rvalid;
    logic                           rready;
    logic                           clear_counts;
    logic [bridge_pkg::COUNT_W-1:0] write_count;
    logic [bridge_pkg::COUNT_W-1:0] read_count;
    logic                           busy;

    logic [7:0] exp_q[$];       // Response bytes still owed by the DUT
    mem_t       shadow;
    int         ok_writes = 0;
    int         ok_reads = 0;
    int         cycles = 0;

    uart_axi_bridge uut (.*);
    tb_axi_mem u_mem (.*);

    initial clk = 1'b0;
    always #50 clk = ~clk;      // 100 ns period

    always @(posedge clk) begin
        cycles <= cycles + 1;
        if (cycles >= CYCLE_LIMIT) begin
            $display("Timeout after %0d cycles, the DUT stopped answering", cycles);
            $display("Finished with errors");
            $fatal(1, "Run stopped by timeout");
        end
    end

    task automatic check(input logic [31:0] got, input logic [31:0] exp, input string what);
        if (got !== exp) begin
            $display("ERROR at time %0t: %s is %h, expected %h", $time, what, got, exp);
            $display("Finished with errors");
            $fatal(1, "Value mismatch");
        end
    endtask

    // Must match the memory model's reset contents
    function automatic logic [31:0] fill_word(input int idx);
        return 32'h0101_0101 * (32'(idx) * 32'd4 + 32'd7);
    endfunction

    function automatic byte_q_t build_request(input logic [7:0] cmd, input logic [31:0] addr,
                                              input logic [31:0] data, input logic [7:0] corrupt);
        byte_q_t    f;
        logic [7:0] sum;
        f.push_back(bridge_pkg::REQ_SOF);
        f.push_back(cmd);
        for (int i = 0; i < 4; i++) begin
            f.push_back(addr[8*i +: 8]);    // LSB first
        end
        if (cmd == bridge_pkg::CMD_WRITE) begin
            for (int i = 0; i < 4; i++) begin
                f.push_back(data[8*i +: 8]);
            end
        end
        sum = 8'h00;
        for (int i = 1; i < f.size(); i++) begin
            sum = sum ^ f[i];
        end
        f.push_back(sum ^ corrupt);         // Nonzero corrupt breaks it
        return f;
    endfunction

    // Reference model of one request frame
    function automatic byte_q_t expected_response(input byte_q_t req, input mem_t mem,
                                                  output logic [7:0] status);
        byte_q_t     rsp;
        logic [7:0]  cmd;
        logic [7:0]  echo;
        logic [7:0]  sum;
        logic [31:0] addr;
        logic [31:0] word;
        cmd  = req[1];
        addr = {req[5], req[4], req[3], req[2]};
        sum  = 8'h00;
        for (int i = 1; i < req.size(); i++) begin
            sum = sum ^ req[i];             // Includes checksum so zero when good
        end
        echo = (cmd == bridge_pkg::CMD_WRITE) ? bridge_pkg::CMD_WRITE : bridge_pkg::CMD_READ;
        if (sum != 8'h00) begin
            status = bridge_pkg::ST_CHECKSUM;
        end else if (cmd != bridge_pkg::CMD_WRITE && cmd != bridge_pkg::CMD_READ) begin
            status = bridge_pkg::ST_BAD_CMD;
            echo   = 8'hFF;
        end else if (addr[1:0] != 2'b00) begin
            status = bridge_pkg::ST_UNALIGNED;
        end else if (addr >= 32'h40) begin
            status = bridge_pkg::ST_BUS_ERR;
        end else begin
            status = bridge_pkg::ST_OK;
        end
        rsp.push_back(bridge_pkg::RSP_SOF);
        rsp.push_back(status);
        rsp.push_back(echo);
        if (echo == bridge_pkg::CMD_READ && status == bridge_pkg::ST_OK) begin
            word = mem[addr[5:2]];
            for (int i = 0; i < 4; i++) begin
                rsp.push_back(word[8*i +: 8]);
            end
        end
        sum = 8'h00;
        for (int i = 1; i < rsp.size(); i++) begin
            sum = sum ^ rsp[i];
        end
        rsp.push_back(sum);
        return rsp;
    endfunction

    task automatic send_byte(input logic [7:0] b);
        logic [9:0] bits;
        bits = {1'b1, b, 1'b0};             // Stop, data, start
        for (int i = 0; i < 10; i++) begin
            @(posedge clk);
            #1;
            rxd = bits[i];
            repeat (bridge_pkg::CLKS_PER_BIT - 16'd1) @(posedge clk);
        end
    endtask

    task automatic send_frame(input byte_q_t f);
        foreach (f[i]) begin
            send_byte(f[i]);
        end
    endtask

    // Queue the expected answer then send it and wait for the drain
    task automatic transact(input logic [7:0] cmd, input logic [31:0] addr,
                            input logic [31:0] data, input logic [7:0] corrupt);
        byte_q_t    req;
        byte_q_t    rsp;
        logic [7:0] status;
        req = build_request(cmd, addr, data, corrupt);
        rsp = expected_response(req, shadow, status);
        if (status == bridge_pkg::ST_OK && cmd == bridge_pkg::CMD_WRITE) begin
            shadow[addr[5:2]] = data;
            ok_writes++;
        end else if (status == bridge_pkg::ST_OK && cmd == bridge_pkg::CMD_READ) begin
            ok_reads++;
        end
        foreach (rsp[i]) begin
            exp_q.push_back(rsp[i]);
        end
        send_frame(req);
        while (exp_q.size() != 0) begin
            @(posedge clk);
        end
        // Stop bit of the checksum byte still on the line
        @(negedge clk);
        check(32'(busy), 32'd1, "busy during last response byte");
        while (busy) begin
            @(negedge clk);
        end
    endtask

    // UART receiver and byte compare on the falling clock edge
    initial begin : compare_bytes
        logic [7:0] b;
        wait (rst == 1'b0);
        forever begin
            @(negedge txd);
            repeat (bridge_pkg::CLKS_PER_BIT / 16'd2) @(negedge clk);
            check(32'(txd), 32'd0, "start bit");
            for (int i = 0; i < 8; i++) begin
                repeat (bridge_pkg::CLKS_PER_BIT) @(negedge clk);
                b[i] = txd;
            end
            repeat (bridge_pkg::CLKS_PER_BIT) @(negedge clk);
            check(32'(txd), 32'd1, "stop bit");
            if (exp_q.size() == 0) begin
                $display("DUT sent byte %h when no response was expected", b);
                $display("Finished with errors");
                $fatal(1, "Unexpected byte");
            end
            check(32'(b), 32'(exp_q.pop_front()), "response byte");
        end
    end

    initial begin
        logic [7:0]  cmd;
        logic [31:0] addr;
        logic [31:0] data;
        logic [7:0]  corrupt;
        void'($urandom(24));
        rst          = 1'b1;
        rxd          = 1'b1;                // Idle line
        clear_counts = 1'b0;
        for (int i = 0; i < 16; i++) begin
            shadow[i] = fill_word(i);
        end
        repeat (10) @(posedge clk);
        #1;
        rst = 1'b0;
        repeat (5) @(posedge clk);

        // Write then read back
        transact(bridge_pkg::CMD_WRITE, 32'h10, 32'hDEAD_BEEF, 8'h00);
        transact(bridge_pkg::CMD_READ, 32'h10, 32'h0, 8'h00);
        // Bad checksum must leave memory alone
        transact(bridge_pkg::CMD_WRITE, 32'h10, 32'h1234_5678, 8'h40);
        transact(bridge_pkg::CMD_READ, 32'h10, 32'h0, 8'h00);
        // Error frames carry no data bytes back
        transact(8'h33, 32'h0, 32'h0, 8'h00);
        transact(bridge_pkg::CMD_READ, 32'h6, 32'h0, 8'h00);
        transact(bridge_pkg::CMD_WRITE, 32'h44, 32'hCAFE_F00D, 8'h00);
        transact(bridge_pkg::CMD_READ, 32'h80, 32'h0, 8'h00);
        // Noise ahead of the start byte
        send_byte(8'h00);
        send_byte(8'h5A);
        send_byte(8'hFF);
        transact(bridge_pkg::CMD_READ, 32'h3C, 32'h0, 8'h00);

        for (int n = 0; n < RANDOM_REQS; n++) begin
            cmd  = ($urandom_range(0, 1) == 0) ? bridge_pkg::CMD_WRITE : bridge_pkg::CMD_READ;
            addr = 32'($urandom_range(0, 19)) << 2;     // Words 16 up are unmapped
            if ($urandom_range(0, 3) == 0) begin
                addr[1:0] = 2'($urandom_range(1, 3));
            end
            data    = $urandom;
            corrupt = ($urandom_range(0, 7) == 0) ? 8'($urandom_range(1, 255)) : 8'h00;
            transact(cmd, addr, data, corrupt);
        end

        #1;
        check(32'(write_count), 32'(ok_writes), "write_count");
        check(32'(read_count), 32'(ok_reads), "read_count");
        @(posedge clk);
        #1;
        clear_counts = 1'b1;
        @(posedge clk);
        #1;
        clear_counts = 1'b0;
        check(32'(write_count), 32'd0, "write_count after clear");
        check(32'(read_count), 32'd0, "read_count after clear");

        $display("Finished with no errors");
        $finish;
    end

endmodule

//--- sources.f
hw/bridge_pkg.sv
hw/uart_rx.sv
hw/uart_tx.sv
hw/frame_parser.sv
hw/axi_lite_master.sv
hw/frame_builder.sv
hw/uart_axi_bridge.sv
tests/tb_axi_mem.sv
tests/tb_uart_axi_bridge.sv

//--- Makefile
SIM := obj_dir/Vtb_uart_axi_bridge

.PHONY: all run clean

all: run

$(SIM): sources.f $(shell cat sources.f)
	verilator --binary --timing -Wno-fatal --top-module tb_uart_axi_bridge -f sources.f

run: $(SIM)
	@out="$$(./$(SIM))"; echo "$$out"; echo "$$out" | grep -q "Finished with no errors"

clean:
	rm -rf obj_dir
